// File: common/cart_config.svh
//////////////////////////////////////////////////
// Header addresses, cartridge ID strings, lightgun
// default and cheat download index
//////////////////////////////////////////////////
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// Cartridge header layout
`define CART_ID_ADDR      25'h180
`define CART_CRC_ADDR     25'h18E
`define CART_QUIRK_ADDR   25'h190
`define CART_RGN_ADDR0    25'h1F0
`define CART_RGN_ADDR1    25'h1F2
`define CART_HDR_END      25'h200
`define REALTEC_ADDR      25'h7E100

`define GUN_DELAY_DEFAULT 8'd44
`define CHEAT_INDEX       8'hFF

// Per-game IDs, serial part of the header
`define ID_BANK_EEP_0     "T-081276"
`define ID_BANK_EEP_1     "T-81406 "
`define ID_EEP_MAP1       "T-50446 "
`define ID_EEP_MAP2       "G-4060  "
`define ID_EEP_MAP3       "T-081326"
`define ID_NORAM          "T-113016"
`define ID_FMBUSY_0       "T-35036 "
`define ID_FMBUSY_1       "T-25073 "
`define ID_SF001          "SF-001"
`define ID_SF002          "SF-002"
`define ID_SF004          "SF-004"
`define SF001_CRC         16'h3E08
`define ID_GUN_BODY_COUNT "MK-1533 "
`define ID_GUN_LETHAL     "T-95096-"
`define ID_GUN_LETHAL_2   "T-95136-"
`define ID_GUN_T2         "T-081156"
`define REALTEC_ID        "SEGA"

`endif

// File: common/ioctl_pkg.sv
//////////////////////////////////////////////////
// Download stream word and download event types
//////////////////////////////////////////////////
package ioctl_pkg;

	// One word of the download stream, wr is a single-cycle strobe
	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;
	} ioctl_beat_t;

	// Download events seen by the header logic
	typedef struct packed {
		logic start;  // One cycle, download began
		logic done;   // One cycle, download ended
		logic active; // Cartridge download in progress
	} dl_event_t;

endpackage

// File: common/cart_pkg.sv
//////////////////////////////////////////////////
// Region, quirk, cartridge info and cheat types
//////////////////////////////////////////////////
package cart_pkg;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	typedef enum logic [1:0] {
		FILE_EXT = 2'd0,
		HEADER   = 2'd1,
		DISABLED = 2'd2
	} region_mode_t;

	// First entry of each order is the fallback
	typedef enum logic [1:0] {
		PRIO_UEJ = 2'd0,
		PRIO_EUJ = 2'd1,
		PRIO_UJE = 2'd2,
		PRIO_JUE = 2'd3
	} region_prio_t;

	typedef struct packed {
		logic    valid;
		region_t region;
	} region_req_t;

	typedef logic [87:0] cart_id_t;

	typedef struct packed {
		logic [2:0] eeprom_map;
		logic       bank_eeprom;
		logic       noram;
		logic       fmbusy;
		logic       realtec;
		logic [2:0] sf_map;
		logic       gun_type;
		logic [7:0] gun_delay;
	} quirk_t;

	typedef struct packed {
		logic [24:0] rom_size;
		logic        s32x;
		quirk_t      quirk;
		logic        valid;
	} cart_info_t;

	// Strobe on top, then fields in big-endian code order
	typedef struct packed {
		logic        strobe;
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		region_mode_t mode;
		region_prio_t prio;
	} settings_t;

endpackage

// File: src/download_tracker.sv
//////////////////////////////////////////////////
// Download edge events, ROM size and 32X flag
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_config.svh"

module download_tracker import ioctl_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_beat_t ioctl,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	output dl_event_t   dl,
	output logic [24:0] rom_size,
	output logic        s32x,
	output logic        info_valid
);

	logic        cart_dl;
	logic        dl_rise;
	logic        dl_fall;
	logic [24:0] last_addr;

	assign cart_dl = ioctl_download && (ioctl_index != `CHEAT_INDEX); // Cheat index excluded
	assign dl_rise = cart_dl && !dl.active;
	assign dl_fall = !cart_dl && dl.active;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl         <= '0;
			s32x       <= 1'b0;
			info_valid <= 1'b0;
		end else begin
			dl.active <= cart_dl;
			dl.start  <= dl_rise;
			dl.done   <= dl_fall;
			if (dl_rise)
				s32x <= &ioctl_index[7:6];
			if (dl.start)
				info_valid <= 1'b0;
			else if (dl.done)
				info_valid <= 1'b1; // Info stable once the download is over
		end
	end

	// Last cartridge word address becomes the ROM size
	always_ff @(posedge clk_sys) begin
		if (ioctl.wr && cart_dl)
			last_addr <= ioctl.addr;
		if (dl_fall)
			rom_size <= last_addr;
	end

endmodule

// File: cart_header/header_field_capture.sv
//////////////////////////////////////////////////
// Byte-swapped header field capture
//////////////////////////////////////////////////
`timescale 1ns/100ps

module header_field_capture import ioctl_pkg::*; #(
	parameter type         T     = logic [15:0],
	parameter logic [24:0] ADDR  = '0,
	parameter int          WORDS = 1
) (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_beat_t ioctl,
	input  dl_event_t   dl,
	output T            field
);

	localparam int BUF_W = WORDS * 16;

	logic [BUF_W-1:0] buf_q;

	// First word lands in the top bits, an odd tail byte is dropped
	always_ff @(posedge clk_sys) begin
		if (RESET || dl.start) begin
			buf_q <= '0;
		end else if (ioctl.wr) begin
			for (int k = 0; k < WORDS; k++) begin
				if (ioctl.addr == ADDR + 25'(2 * k))
					buf_q[BUF_W-1-16*k -: 16] <= {ioctl.data[7:0], ioctl.data[15:8]};
			end
		end
	end

	assign field = T'(buf_q[BUF_W-1 -: $bits(T)]);

endmodule

// File: cart_header/region_detect.sv
//////////////////////////////////////////////////
// Region letters from the header, region request
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_config.svh"

module region_detect import ioctl_pkg::*, cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_beat_t ioctl,
	input  dl_event_t   dl,
	input  logic [7:0]  ioctl_index,
	input  settings_t   settings,
	output region_req_t region_req
);

	logic [2:0] hdr_flags; // {E, U, J}
	logic [2:0] word_flags;
	logic       hdr_end_q;

	// Letter to flags, old headers may carry a hex digit instead
	function automatic logic [2:0] char_flags(input logic [7:0] c, input logic hex_ok);
		logic [3:0] hx;
		hx = c[3:0] - 4'd7;
		if (c == "J")
			return 3'b001;
		else if (c == "U")
			return 3'b010;
		else if (c == "E")
			return 3'b100;
		else if (hex_ok && c >= "0" && c <= "9")
			return {c[3], c[2], c[0]};
		else if (hex_ok && c >= "A" && c <= "F")
			return {hx[3], hx[2], hx[0]};
		return 3'b000;
	endfunction

	function automatic region_t pick(input region_prio_t prio, input logic [2:0] f);
		case (prio)
			PRIO_EUJ: return f[2] ? EU : f[1] ? US : f[0] ? JP : EU;
			PRIO_UJE: return f[1] ? US : f[0] ? JP : f[2] ? EU : US;
			PRIO_JUE: return f[0] ? JP : f[1] ? US : f[2] ? EU : JP;
			default:  return f[1] ? US : f[2] ? EU : f[0] ? JP : US;
		endcase
	endfunction

	always_comb begin
		word_flags = '0;
		if (ioctl.addr == `CART_RGN_ADDR0)
			word_flags = char_flags(ioctl.data[7:0], 1'b1) | char_flags(ioctl.data[15:8], 1'b0);
		else if (ioctl.addr == `CART_RGN_ADDR1)
			word_flags = char_flags(ioctl.data[7:0], 1'b0) | char_flags(ioctl.data[15:8], 1'b0);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_flags  <= '0;
			hdr_end_q  <= 1'b0;
			region_req <= '0;
		end else begin
			hdr_end_q <= ioctl.wr && (ioctl.addr == `CART_HDR_END);
			if (dl.start)
				hdr_flags <= '0;
			else if (ioctl.wr)
				hdr_flags <= hdr_flags | word_flags;

			// Second stage, flags are final by now
			region_req.valid <= hdr_end_q &&
				(settings.mode == HEADER || settings.mode == FILE_EXT);
			if (hdr_end_q) begin
				if (settings.mode == HEADER)
					region_req.region <= pick(settings.prio, hdr_flags);
				else
					region_req.region <= region_t'(ioctl_index[7:6]); // From file extension
			end
		end
	end

endmodule

// File: cart_header/quirk_lookup.sv
//////////////////////////////////////////////////
// Per-game quirk table lookup
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_config.svh"

module quirk_lookup import ioctl_pkg::*, cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_beat_t ioctl,
	input  dl_event_t   dl,
	input  cart_id_t    cart_id,
	input  logic [15:0] crc,
	input  logic [31:0] realtec_id,
	output quirk_t      quirk
);

	logic [63:0] id8; // Serial field
	logic [47:0] id6; // Short IDs of unlicensed carts

	assign id8 = cart_id[63:0];
	assign id6 = cart_id[87:40];

	always_ff @(posedge clk_sys) begin
		if (RESET || dl.start) begin
			quirk <= '0;
		end else if (ioctl.wr) begin
			if (ioctl.addr == `CART_QUIRK_ADDR) begin
				// Mapper quirks, first match wins
				if (id8 == `ID_BANK_EEP_0 || id8 == `ID_BANK_EEP_1)
					quirk.bank_eeprom <= 1'b1;
				else if (id8 == `ID_EEP_MAP1)
					quirk.eeprom_map <= 3'b001;
				else if (id8 == `ID_EEP_MAP2)
					quirk.eeprom_map <= 3'b010;
				else if (id8 == `ID_EEP_MAP3)
					quirk.eeprom_map <= 3'b011;
				else if (id8 == `ID_NORAM)
					quirk.noram <= 1'b1;
				else if (id8 == `ID_FMBUSY_0 || id8 == `ID_FMBUSY_1)
					quirk.fmbusy <= 1'b1;
				else if (id6 == `ID_SF001)
					quirk.sf_map <= {crc == `SF001_CRC, 2'b01}; // Revision told apart by CRC
				else if (id6 == `ID_SF002)
					quirk.sf_map <= 3'b110;
				else if (id6 == `ID_SF004)
					quirk.sf_map <= 3'b111;

				// Lightgun type and sensor delay
				if (id8 == `ID_GUN_BODY_COUNT) begin
					quirk.gun_type  <= 1'b0;
					quirk.gun_delay <= 8'd100;
				end else if (id8 == `ID_GUN_LETHAL) begin
					quirk.gun_type  <= 1'b1;
					quirk.gun_delay <= 8'd52;
				end else if (id8 == `ID_GUN_LETHAL_2) begin
					quirk.gun_type  <= 1'b1;
					quirk.gun_delay <= 8'd30;
				end else if (id8 == `ID_GUN_T2) begin
					quirk.gun_type  <= 1'b0;
					quirk.gun_delay <= 8'd126;
				end else begin
					quirk.gun_type  <= 1'b0;
					quirk.gun_delay <= `GUN_DELAY_DEFAULT;
				end
			end

			// Realtec signature is complete two words later
			if (ioctl.addr == (`REALTEC_ADDR + 25'd4) && realtec_id == `REALTEC_ID)
				quirk.realtec <= 1'b1;
		end
	end

endmodule

// File: cheat/cheat_code_loader.sv
//////////////////////////////////////////////////
// Cheat code assembly from download words
//////////////////////////////////////////////////
`timescale 1ns/100ps

module cheat_code_loader import ioctl_pkg::*, cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_beat_t ioctl,
	input  logic        cheat_sel,
	output cheat_code_t cheat,
	output logic        cheat_clear
);

	logic        code_wr;
	logic        strobe_q;
	logic [31:0] flags_q;
	logic [31:0] addr_q;
	logic [31:0] cmp_q;
	logic [31:0] repl_q;

	assign code_wr = ioctl.wr && cheat_sel;

	// Eight words per code, low half first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				4'd0:    flags_q[15:0]  <= ioctl.data;
				4'd2:    flags_q[31:16] <= ioctl.data;
				4'd4:    addr_q[15:0]   <= ioctl.data;
				4'd6:    addr_q[31:16]  <= ioctl.data;
				4'd8:    cmp_q[15:0]    <= ioctl.data;
				4'd10:   cmp_q[31:16]   <= ioctl.data;
				4'd12:   repl_q[15:0]   <= ioctl.data;
				4'd14:   repl_q[31:16]  <= ioctl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			strobe_q    <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Address bit 31 marks a disabled code
			strobe_q    <= code_wr && (ioctl.addr[3:0] == 4'd14) && !addr_q[31];
			cheat_clear <= code_wr && (ioctl.addr == '0); // New cheat file
		end
	end

	assign cheat = '{strobe: strobe_q, flags: flags_q, addr: addr_q,
		compare: cmp_q, replace: repl_q};

endmodule

// File: src/cart_loader_top.sv
//////////////////////////////////////////////////
// Cartridge load front end, top level
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_config.svh"

module cart_loader_top import ioctl_pkg::*, cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_beat_t ioctl,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  settings_t   settings,
	output cart_info_t  cart_info,
	output region_req_t region_req,
	output cheat_code_t cheat,
	output logic        cheat_clear
);

	dl_event_t   dl;
	ioctl_beat_t cart_beat;
	logic        cheat_sel;
	logic [24:0] rom_size;
	logic        s32x;
	logic        info_valid;
	cart_id_t    cart_id;
	logic [15:0] crc;
	logic [31:0] realtec_id;
	quirk_t      quirk;

	// Cheat words never reach the header logic
	assign cheat_sel = ioctl_download && (ioctl_index == `CHEAT_INDEX);
	assign cart_beat = '{wr: ioctl.wr && ioctl_download && !cheat_sel,
		addr: ioctl.addr, data: ioctl.data};

	assign cart_info = '{rom_size: rom_size, s32x: s32x, quirk: quirk, valid: info_valid};

	download_tracker u_download_tracker (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl(ioctl), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .dl(dl), .rom_size(rom_size), .s32x(s32x),
		.info_valid(info_valid)
	);

	header_field_capture #(.T(cart_id_t), .ADDR(`CART_ID_ADDR), .WORDS(6)) u_id_capture (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl(cart_beat), .dl(dl), .field(cart_id)
	);

	header_field_capture #(.T(logic [15:0]), .ADDR(`CART_CRC_ADDR), .WORDS(1)) u_crc_capture (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl(cart_beat), .dl(dl), .field(crc)
	);

	header_field_capture #(.T(logic [31:0]), .ADDR(`REALTEC_ADDR), .WORDS(2)) u_rt_capture (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl(cart_beat), .dl(dl), .field(realtec_id)
	);

	quirk_lookup u_quirk_lookup (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl(cart_beat), .dl(dl), .cart_id(cart_id),
		.crc(crc), .realtec_id(realtec_id), .quirk(quirk)
	);

	region_detect u_region_detect (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl(cart_beat), .dl(dl),
		.ioctl_index(ioctl_index), .settings(settings), .region_req(region_req)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl(ioctl), .cheat_sel(cheat_sel),
		.cheat(cheat), .cheat_clear(cheat_clear)
	);

endmodule

// File: verif/cart_assert.sv
//////////////////////////////////////////////////
// Concurrent assertions on the output strobes
//////////////////////////////////////////////////
`timescale 1ns/100ps

module cart_assert import cart_pkg::*; (
	input logic        clk_sys,
	input logic        RESET,
	input settings_t   settings,
	input region_req_t region_req,
	input cheat_code_t cheat,
	input logic        cheat_clear
);

	// Single-cycle pulses
	a_region_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		region_req.valid |=> !region_req.valid)
		else $error("region_req.valid held longer than one cycle");

	a_cheat_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat.strobe |=> !cheat.strobe)
		else $error("cheat.strobe held longer than one cycle");

	a_clear_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_clear |=> !cheat_clear)
		else $error("cheat_clear held longer than one cycle");

	a_no_region_disabled: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(region_req.valid) |-> settings.mode != DISABLED)
		else $error("region request while region mode is disabled");

	a_quiet_reset: assert property (@(posedge clk_sys)
		RESET |-> !$rose(region_req.valid) && !$rose(cheat.strobe) && !$rose(cheat_clear))
		else $error("strobe rose during reset");

endmodule

// File: verif/cart_checker.sv
//////////////////////////////////////////////////
// Output monitor, value compares, error counts
//////////////////////////////////////////////////
`timescale 1ns/100ps

module cart_checker import cart_pkg::*; (
	input logic        clk_sys,
	input logic        RESET,
	input cart_info_t  cart_info,
	input region_req_t region_req,
	input cheat_code_t cheat,
	input logic        cheat_clear
);

	int          errors = 0;
	int          checks = 0;
	int          region_pulses = 0;
	int          cheat_strobes = 0;
	int          clear_pulses = 0;
	region_t     last_region = JP;
	logic [127:0] last_code = '0; // Code fields at the strobe

	// Pulse counters
	always @(posedge clk_sys) begin
		if (!RESET) begin
			if (region_req.valid) begin
				region_pulses <= region_pulses + 1;
				last_region   <= region_req.region;
			end
			if (cheat.strobe) begin
				cheat_strobes <= cheat_strobes + 1;
				last_code     <= {cheat.flags, cheat.addr, cheat.compare, cheat.replace};
			end
			if (cheat_clear)
				clear_pulses <= clear_pulses + 1;
		end
	end

	task automatic check_value(input string name, input string what,
		input logic [127:0] exp, input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s %s expected %0h actual %0h", name, what, exp, act);
		end
	endtask

	task automatic check_info(input string name, input logic [24:0] rom,
		input logic s32x, input quirk_t q);
		check_value(name, "rom_size", 128'(rom), 128'(cart_info.rom_size));
		check_value(name, "s32x", 128'(s32x), 128'(cart_info.s32x));
		check_value(name, "quirk", 128'(q), 128'(cart_info.quirk));
	endtask

	task automatic check_region(input string name, input logic vld,
		input region_t rgn, input int prev);
		check_value(name, "region pulses", 128'(prev + int'(vld)), 128'(region_pulses));
		if (vld)
			check_value(name, "region", 128'(rgn), 128'(last_region));
	endtask

	task automatic check_cheat(input string name, input logic [127:0] code,
		input int strobes, input int clears);
		check_value(name, "cheat strobes", 128'(strobes), 128'(cheat_strobes));
		check_value(name, "cheat clears", 128'(clears), 128'(clear_pulses));
		check_value(name, "cheat code", code, last_code);
	endtask

endmodule

// File: verif/tb_top.sv
//////////////////////////////////////////////////
// Testbench top, clock, reset, case table
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "cart_config.svh"

module tb_top import ioctl_pkg::*, cart_pkg::*; ();

	localparam int N_CASES = 16;

	logic        clk_sys = 1'b0;
	logic        RESET;
	ioctl_beat_t ioctl;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	settings_t   settings;
	cart_info_t  cart_info;
	region_req_t region_req;
	cheat_code_t cheat;
	logic        cheat_clear;
	integer      seed;

	// Case table
	string       tc_name [N_CASES];
	logic [7:0]  tc_index[N_CASES];
	logic [87:0] tc_id   [N_CASES];
	logic [31:0] tc_rgn  [N_CASES]; // Bytes at 0x1F0 to 0x1F3
	logic [15:0] tc_crc  [N_CASES];
	logic        tc_rt   [N_CASES]; // Realtec signature present
	logic        tc_s32x [N_CASES]; // 32X flag expected
	settings_t   tc_set  [N_CASES];
	logic        tc_rvld [N_CASES];
	region_t     tc_rexp [N_CASES];
	quirk_t      tc_quirk[N_CASES];
	int          n_cases = 0;

	always #20 clk_sys = ~clk_sys;

	cart_loader_top u_cart_loader_top (.*);

	cart_checker u_cart_checker (.*);

	bind cart_loader_top cart_assert u_cart_assert (.*);

	task automatic add_case(input string name, input logic [7:0] idx, input logic [87:0] id,
		input logic [31:0] rgn, input logic [15:0] crc, input logic rt,
		input region_mode_t mode, input region_prio_t prio, input logic rvld,
		input region_t rexp, input quirk_t q);
		tc_name[n_cases]  = name;
		tc_index[n_cases] = idx;
		tc_id[n_cases]    = id;
		tc_rgn[n_cases]   = rgn;
		tc_crc[n_cases]   = crc;
		tc_rt[n_cases]    = rt;
		tc_s32x[n_cases]  = 1'b0;
		tc_set[n_cases]   = '{mode: mode, prio: prio};
		tc_rvld[n_cases]  = rvld;
		tc_rexp[n_cases]  = rexp;
		tc_quirk[n_cases] = q;
		n_cases++;
	endtask

	function automatic quirk_t plain_quirk();
		quirk_t q;
		q = '0;
		q.gun_delay = `GUN_DELAY_DEFAULT;
		return q;
	endfunction

	// Synthetic ROM, random filler outside the header fields
	function automatic logic [7:0] rom_byte(input int k, input logic [24:0] a);
		logic [31:0] rt_sig;
		rt_sig = "SEGA";
		if (a >= 25'h180 && a <= 25'h18A)
			return tc_id[k][87 - 8 * int'(a - 25'h180) -: 8];
		else if (a == 25'h18E)
			return tc_crc[k][15:8];
		else if (a == 25'h18F)
			return tc_crc[k][7:0];
		else if (a >= `CART_RGN_ADDR0 && a <= 25'h1F3)
			return tc_rgn[k][31 - 8 * int'(a - `CART_RGN_ADDR0) -: 8];
		else if (tc_rt[k] && a >= `REALTEC_ADDR && a <= 25'h7E103)
			return rt_sig[31 - 8 * int'(a - `REALTEC_ADDR) -: 8];
		return 8'($random(seed));
	endfunction

	task automatic send_word(input logic [24:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		ioctl <= '{wr: 1'b1, addr: a, data: d};
	endtask

	task automatic end_stream();
		@(posedge clk_sys);
		ioctl.wr       <= 1'b0;
		ioctl_download <= 1'b0;
	endtask

	task automatic run_case(input int k);
		logic [24:0] a;
		logic [7:0]  lo;
		logic [7:0]  hi;
		@(posedge clk_sys);
		ioctl_index <= tc_index[k];
		settings    <= tc_set[k];
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		for (a = 25'h0; a <= 25'h20E; a = a + 25'd2) begin
			lo = rom_byte(k, a);
			hi = rom_byte(k, a + 25'd1);
			send_word(a, {hi, lo});
		end
		if (tc_rt[k]) begin
			for (a = `REALTEC_ADDR; a <= `REALTEC_ADDR + 25'd4; a = a + 25'd2) begin
				lo = rom_byte(k, a);
				hi = rom_byte(k, a + 25'd1);
				send_word(a, {hi, lo});
			end
		end
		end_stream();
	endtask

	task automatic wait_info(input string name);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!cart_info.valid && n < 50) begin
			@(negedge clk_sys);
			n++;
		end
		if (!cart_info.valid) begin
			$display("Timeout in %s, cart_info.valid never rose", name);
			$display("Testbench failed");
			$finish;
		end
	endtask

	// Eight words, low half of each field first
	task automatic send_code(input logic [24:0] base, input logic [127:0] c);
		for (int w = 0; w < 8; w++)
			send_word(base + 25'(2 * w), c[127 - 32 * (w / 2) - 16 * (1 - w % 2) -: 16]);
	endtask

	task automatic run_cheat();
		logic [127:0] code_a;
		logic [127:0] code_b;
		int           n;
		code_a = {32'h0000_0001, 32'h00FF_1234, 32'h0000_ABCD, 32'h0000_4E71};
		code_b = {32'h0000_0002, 32'h8000_1000, 32'h0000_0000, 32'h0000_FFFF};
		n = 0;
		@(posedge clk_sys);
		ioctl_index <= `CHEAT_INDEX;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		send_code(25'h0, code_a);
		@(posedge clk_sys);
		ioctl.wr <= 1'b0;
		repeat (2) @(posedge clk_sys);
		send_code(25'h10, code_b); // Disabled code
		end_stream();
		@(negedge clk_sys);
		while (u_cart_checker.cheat_strobes < 1 && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (u_cart_checker.cheat_strobes < 1) begin
			$display("Timeout in cheat_load, no cheat strobe seen");
			$display("Testbench failed");
			$finish;
		end
		repeat (4) @(negedge clk_sys);
		u_cart_checker.check_cheat("cheat_load", code_a, 1, 1);
	endtask

	initial begin
		quirk_t q;
		int     prev;
		seed           = 32'h2c58e94f;
		RESET          = 1'b1;
		ioctl          = '0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		settings       = '{mode: HEADER, prio: PRIO_UEJ};

		q = plain_quirk();
		add_case("jue_uej", 8'h00, "GM 00000000", "JUE ", 16'h0, 0, HEADER, PRIO_UEJ, 1, US, q);
		add_case("jue_euj", 8'h00, "GM 00000000", "JUE ", 16'h0, 0, HEADER, PRIO_EUJ, 1, EU, q);
		add_case("jue_uje", 8'h00, "GM 00000000", "JUE ", 16'h0, 0, HEADER, PRIO_UJE, 1, US, q);
		add_case("jue_jue", 8'h00, "GM 00000000", "JUE ", 16'h0, 0, HEADER, PRIO_JUE, 1, JP, q);
		add_case("blank_euj", 8'h00, "GM 00000000", "    ", 16'h0, 0, HEADER, PRIO_EUJ, 1, EU, q);
		add_case("blank_jue", 8'h00, "GM 00000000", "    ", 16'h0, 0, HEADER, PRIO_JUE, 1, JP, q);
		add_case("hex5_euj", 8'h00, "GM 00000000", "5   ", 16'h0, 0, HEADER, PRIO_EUJ, 1, US, q);
		add_case("hexA_uje", 8'h00, "GM 00000000", "A   ", 16'h0, 0, HEADER, PRIO_UJE, 1, EU, q);
		add_case("file_ext", 8'h80, "GM 00000000", "J   ", 16'h0, 0, FILE_EXT, PRIO_UEJ, 1, EU, q);
		add_case("disabled", 8'h00, "GM 00000000", "JUE ", 16'h0, 0, DISABLED, PRIO_UEJ, 0, JP, q);
		add_case("s32x", 8'hC0, "GM 00000000", "JUE ", 16'h0, 0, HEADER, PRIO_UEJ, 1, US, q);
		tc_s32x[n_cases - 1] = 1'b1;
		q = plain_quirk();
		q.bank_eeprom = 1'b1;
		add_case("bank_eep", 8'h00, "GM T-081276", "U   ", 16'h0, 0, HEADER, PRIO_UEJ, 1, US, q);
		q = plain_quirk();
		q.sf_map = 3'b101;
		add_case("sf001", 8'h00, "SF-001     ", "U   ", 16'h3E08, 0, HEADER, PRIO_UEJ, 1, US, q);
		q = plain_quirk();
		q.gun_type  = 1'b1;
		q.gun_delay = 8'd52;
		add_case("gun_lethal", 8'h00, "GM T-95096-", "U   ", 16'h0, 0, HEADER, PRIO_UEJ, 1, US, q);
		q = plain_quirk();
		q.noram = 1'b1;
		add_case("noram", 8'h00, "GM T-113016", "U   ", 16'h0, 0, HEADER, PRIO_UEJ, 1, US, q);
		q = plain_quirk();
		q.realtec = 1'b1;
		add_case("realtec", 8'h00, "GM 12345678", "U   ", 16'h0, 1, HEADER, PRIO_UEJ, 1, US, q);

		repeat (16) @(posedge clk_sys);
		RESET <= 1'b0;

		for (int k = 0; k < n_cases; k++) begin
			prev = u_cart_checker.region_pulses;
			run_case(k);
			wait_info(tc_name[k]);
			u_cart_checker.check_info(tc_name[k], tc_rt[k] ? 25'h7E104 : 25'h20E,
				tc_s32x[k], tc_quirk[k]);
			u_cart_checker.check_region(tc_name[k], tc_rvld[k], tc_rexp[k], prev);
		end
		run_cheat();

		$display("Checks: %0d, errors: %0d", u_cart_checker.checks, u_cart_checker.errors);
		if (u_cart_checker.errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: all.f
+incdir+common
common/ioctl_pkg.sv
common/cart_pkg.sv
src/download_tracker.sv
cart_header/header_field_capture.sv
cart_header/region_detect.sv
cart_header/quirk_lookup.sv
cheat/cheat_code_loader.sv
src/cart_loader_top.sv
verif/cart_assert.sv
verif/cart_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -sv -Wno-fatal -f all.f --top-module tb_top \
	-Mdir obj_dir -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
